// File: build.f
src/axi_pkg.sv
src/axi_if.sv
src/axi_arb_ctrl.sv
src/axi_req_mux.sv
src/axi_rsp_demux.sv
src/axi_sram_slave.sv
src/axi_mem_sys.sv
test/tb_axi_mem_sys.sv

// File: test/tb_axi_mem_sys.sv
// Memory system testbench
`timescale 1ns/1ns

module tb_axi_mem_sys;
  import axi_pkg::*;

  localparam int FILL_WORDS = 64;
  localparam int MAX_CYCLES = 4000;

  logic                  clk;
  logic                  arst_n;
  logic [AXI_ADDR_W-1:0] awaddr [2];
  logic [AXI_ADDR_W-1:0] araddr [2];
  logic [7:0]            awlen  [2];
  logic [7:0]            arlen  [2];
  logic [AXI_DATA_W-1:0] wdata  [2];
  logic [AXI_STRB_W-1:0] wstrb  [2];
  logic                  awvalid [2];
  logic                  wvalid  [2];
  logic                  wlast   [2];
  logic                  bready  [2];
  logic                  arvalid [2];
  logic                  rready  [2];
  wire                   awready [2];
  wire                   wready  [2];
  wire                   bvalid  [2];
  wire                   arready [2];
  wire                   rvalid  [2];
  wire                   rlast   [2];
  wire [1:0]             bresp   [2];
  wire [1:0]             rresp   [2];
  wire [AXI_DATA_W-1:0]  rdata   [2];

  bit                    rd_open [2];  // Read accepted, last beat not yet taken
  bit                    wr_open [2];
  int                    cyc;
  int                    ar_cyc [2];
  int                    aw_cyc [2];
  logic [AXI_DATA_W-1:0] model [int];  // Word index to data

  axi_mem_sys uut (
    .i_aclk (clk), .i_arst_n (arst_n),
    .i_a_awaddr (awaddr[0]), .i_a_awlen (awlen[0]), .i_a_awsize (3'd3),
    .i_a_awburst (2'b01), .i_a_awlock (2'b00), .i_a_awcache (4'd0), .i_a_awprot (3'd0),
    .i_a_awvalid (awvalid[0]), .o_a_awready (awready[0]),
    .i_a_wdata (wdata[0]), .i_a_wstrb (wstrb[0]), .i_a_wlast (wlast[0]),
    .i_a_wvalid (wvalid[0]), .o_a_wready (wready[0]),
    .o_a_bresp (bresp[0]), .o_a_bvalid (bvalid[0]), .i_a_bready (bready[0]),
    .i_a_araddr (araddr[0]), .i_a_arlen (arlen[0]), .i_a_arsize (3'd3),
    .i_a_arburst (2'b01), .i_a_arlock (2'b00), .i_a_arcache (4'd0), .i_a_arprot (3'd0),
    .i_a_arvalid (arvalid[0]), .o_a_arready (arready[0]),
    .o_a_rdata (rdata[0]), .o_a_rresp (rresp[0]), .o_a_rlast (rlast[0]),
    .o_a_rvalid (rvalid[0]), .i_a_rready (rready[0]),
    .i_b_awaddr (awaddr[1]), .i_b_awlen (awlen[1]), .i_b_awsize (3'd3),
    .i_b_awburst (2'b01), .i_b_awlock (2'b00), .i_b_awcache (4'd0), .i_b_awprot (3'd0),
    .i_b_awvalid (awvalid[1]), .o_b_awready (awready[1]),
    .i_b_wdata (wdata[1]), .i_b_wstrb (wstrb[1]), .i_b_wlast (wlast[1]),
    .i_b_wvalid (wvalid[1]), .o_b_wready (wready[1]),
    .o_b_bresp (bresp[1]), .o_b_bvalid (bvalid[1]), .i_b_bready (bready[1]),
    .i_b_araddr (araddr[1]), .i_b_arlen (arlen[1]), .i_b_arsize (3'd3),
    .i_b_arburst (2'b01), .i_b_arlock (2'b00), .i_b_arcache (4'd0), .i_b_arprot (3'd0),
    .i_b_arvalid (arvalid[1]), .o_b_arready (arready[1]),
    .o_b_rdata (rdata[1]), .o_b_rresp (rresp[1]), .o_b_rlast (rlast[1]),
    .o_b_rvalid (rvalid[1]), .i_b_rready (rready[1])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic die(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else
      die($sformatf("ERROR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  // Pattern from the full byte address
  function automatic logic [63:0] fill_word(input int widx);
    logic [31:0] addr;
    addr = widx * 8;
    return {~addr, addr};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] d,
                                              input logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) res[8*i +: 8] = d[8*i +: 8];
    end
    return res;
  endfunction

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) die("Timeout, the tests did not finish in time");
  end

  // --------------------------------------------------
  // Channel tasks
  task automatic write_burst(input int m, input int widx, input int len, input bit fill);
    logic [63:0] d;
    logic [63:0] old;
    logic [7:0]  st;
    @(negedge clk);
    awaddr[m]  = widx * 8;
    awlen[m]   = len;
    awvalid[m] = 1'b1;
    #1;
    while (!awready[m]) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    aw_cyc[m]  = cyc;
    wr_open[m] = 1'b1;
    for (int i = 0; i <= len; i++) begin
      d  = fill ? fill_word(widx + i) : {$urandom, $urandom};
      st = fill ? 8'hff : 8'($urandom);
      @(negedge clk);
      awvalid[m] = 1'b0;
      wdata[m]   = d;
      wstrb[m]   = st;
      wlast[m]   = (i == len);
      wvalid[m]  = 1'b1;
      #1;
      while (!wready[m]) begin
        @(negedge clk);
        #1;
      end
      @(posedge clk);
      old = model.exists(widx + i) ? model[widx + i] : 64'd0;
      model[widx + i] = merge_bytes(old, d, st);
    end
    @(negedge clk);
    wvalid[m] = 1'b0;
    wlast[m]  = 1'b0;
    bready[m] = ($urandom_range(3) != 0);
    #1;
    check_val("bvalid", 1, bvalid[m]);  // One cycle after wlast
    while (!bready[m]) begin
      @(negedge clk);
      bready[m] = ($urandom_range(3) != 0);
      #1;
      check_val("bvalid", 1, bvalid[m]);
    end
    check_val("bresp", RESP_OKAY, bresp[m]);
    @(posedge clk);
    wr_open[m] = 1'b0;
    @(negedge clk);
    bready[m] = 1'b0;
  endtask

  task automatic read_burst(input int m, input int widx, input int len);
    int n;
    n = (len > MAX_BURST - 1) ? MAX_BURST : len + 1;
    @(negedge clk);
    araddr[m]  = widx * 8;
    arlen[m]   = len;
    arvalid[m] = 1'b1;
    #1;
    while (!arready[m]) begin
      @(negedge clk);
      #1;
    end
    @(posedge clk);
    ar_cyc[m]  = cyc;
    rd_open[m] = 1'b1;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      arvalid[m] = 1'b0;
      rready[m]  = ($urandom_range(3) != 0);
      #1;
      check_val("rvalid", 1, rvalid[m]);
      while (!rready[m]) begin
        @(negedge clk);
        rready[m] = ($urandom_range(3) != 0);
        #1;
        check_val("rvalid", 1, rvalid[m]);
      end
      check_val("rdata", model[widx + i], rdata[m]);
      check_val("rlast", (i == n - 1), rlast[m]);
      check_val("rresp", RESP_OKAY, rresp[m]);
      @(posedge clk);
    end
    rd_open[m] = 1'b0;
    @(negedge clk);
    rready[m] = 1'b0;
  endtask

  task automatic random_ops(input int m, input int count);
    int len;
    int widx;
    for (int k = 0; k < count; k++) begin
      if ($urandom_range(1) == 1) begin
        len  = $urandom_range(1);
        widx = $urandom_range(FILL_WORDS - 1 - len);
        write_burst(m, widx, len, 1'b0);
      end else begin
        len  = $urandom_range(3);
        widx = $urandom_range(FILL_WORDS - 1 - len);
        read_burst(m, widx, len);
      end
    end
  endtask

  // --------------------------------------------------
  // Protocol and routing checks
  for (genvar g = 0; g < 2; g++) begin : g_chk
    assert property (@(posedge clk) disable iff (!arst_n)
      rvalid[g] && !rready[g] |=> rvalid[g] && $stable(rdata[g]) && $stable(rlast[g]))
      else die($sformatf("R beat of master %0d changed while stalled", g));
    assert property (@(posedge clk) disable iff (!arst_n)
      bvalid[g] && !bready[g] |=> bvalid[g] && $stable(bresp[g]))
      else die($sformatf("B response of master %0d changed while stalled", g));
    assert property (@(posedge clk) disable iff (!arst_n) !rd_open[g] |-> !rvalid[g])
      else die($sformatf("Read data reached master %0d with no read open", g));
    assert property (@(posedge clk) disable iff (!arst_n) !wr_open[g] |-> !bvalid[g])
      else die($sformatf("Write response reached master %0d with no write open", g));
    assert property (@(posedge clk) disable iff (!arst_n) rd_open[g] |-> !arready[1-g])
      else die($sformatf("AR accepted while a read of master %0d was open", g));
    assert property (@(posedge clk) disable iff (!arst_n) wvalid[g] |-> !bvalid[g])
      else die($sformatf("Write response to master %0d came before the last W beat", g));
  end

  // --------------------------------------------------
  // Test sequence
  initial begin
    void'($urandom(32'hcbaf));
    arst_n = 1'b0;
    cyc    = 0;
    for (int m = 0; m < 2; m++) begin
      awaddr[m]  = '0;
      araddr[m]  = '0;
      awlen[m]   = '0;
      arlen[m]   = '0;
      wdata[m]   = '0;
      wstrb[m]   = '0;
      awvalid[m] = 1'b0;
      wvalid[m]  = 1'b0;
      wlast[m]   = 1'b0;
      bready[m]  = 1'b0;
      arvalid[m] = 1'b0;
      rready[m]  = 1'b0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Quiet outputs, no valid means no ready
    repeat (2) begin
      @(negedge clk);
      #1;
      for (int m = 0; m < 2; m++) begin
        check_val("awready", 0, awready[m]);
        check_val("arready", 0, arready[m]);
        check_val("wready", 0, wready[m]);
        check_val("bvalid", 0, bvalid[m]);
        check_val("rvalid", 0, rvalid[m]);
      end
    end

    for (int k = 0; k < FILL_WORDS; k += 16) write_burst(1, k, 15, 1'b1);

    // Single beats with random strobes from b
    for (int k = 0; k < 8; k++) write_burst(1, k * 7, 0, 1'b0);
    for (int k = 0; k < 8; k++) read_burst(1, k * 7, 0);

    // Bursts from a, one of them clipped
    for (int k = 0; k < 10; k++) begin
      read_burst(0, $urandom_range(FILL_WORDS - 16), $urandom_range(15));
    end
    read_burst(0, 0, 20);

    // Same-cycle requests
    fork
      read_burst(0, 8, 7);
      read_burst(1, 20, 3);
    join
    assert (ar_cyc[0] < ar_cyc[1]) else die("Master a did not win the AR tie");
    fork
      write_burst(0, 30, 3, 1'b0);
      write_burst(1, 40, 2, 1'b0);
    join
    assert (aw_cyc[0] < aw_cyc[1]) else die("Master a did not win the AW tie");
    read_burst(1, 30, 12);

    fork
      random_ops(0, 100);
      random_ops(1, 100);
    join

    repeat (2) @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: src/axi_mem_sys.sv
// Shared AXI memory system
`timescale 1ns/1ns

module axi_mem_sys (
  input  logic                            i_aclk,
  input  logic                            i_arst_n,

  // Master a, instruction fetch
  input  logic [axi_pkg::AXI_ADDR_W-1:0]  i_a_awaddr,
  input  logic [7:0]                      i_a_awlen,
  input  logic [2:0]                      i_a_awsize,
  input  logic [1:0]                      i_a_awburst,
  input  logic [1:0]                      i_a_awlock,
  input  logic [3:0]                      i_a_awcache,
  input  logic [2:0]                      i_a_awprot,
  input  logic                            i_a_awvalid,
  output logic                            o_a_awready,
  input  logic [axi_pkg::AXI_DATA_W-1:0]  i_a_wdata,
  input  logic [axi_pkg::AXI_STRB_W-1:0]  i_a_wstrb,
  input  logic                            i_a_wlast,
  input  logic                            i_a_wvalid,
  output logic                            o_a_wready,
  output logic [1:0]                      o_a_bresp,
  output logic                            o_a_bvalid,
  input  logic                            i_a_bready,
  input  logic [axi_pkg::AXI_ADDR_W-1:0]  i_a_araddr,
  input  logic [7:0]                      i_a_arlen,
  input  logic [2:0]                      i_a_arsize,
  input  logic [1:0]                      i_a_arburst,
  input  logic [1:0]                      i_a_arlock,
  input  logic [3:0]                      i_a_arcache,
  input  logic [2:0]                      i_a_arprot,
  input  logic                            i_a_arvalid,
  output logic                            o_a_arready,
  output logic [axi_pkg::AXI_DATA_W-1:0]  o_a_rdata,
  output logic [1:0]                      o_a_rresp,
  output logic                            o_a_rlast,
  output logic                            o_a_rvalid,
  input  logic                            i_a_rready,

  // Master b, load/store
  input  logic [axi_pkg::AXI_ADDR_W-1:0]  i_b_awaddr,
  input  logic [7:0]                      i_b_awlen,
  input  logic [2:0]                      i_b_awsize,
  input  logic [1:0]                      i_b_awburst,
  input  logic [1:0]                      i_b_awlock,
  input  logic [3:0]                      i_b_awcache,
  input  logic [2:0]                      i_b_awprot,
  input  logic                            i_b_awvalid,
  output logic                            o_b_awready,
  input  logic [axi_pkg::AXI_DATA_W-1:0]  i_b_wdata,
  input  logic [axi_pkg::AXI_STRB_W-1:0]  i_b_wstrb,
  input  logic                            i_b_wlast,
  input  logic                            i_b_wvalid,
  output logic                            o_b_wready,
  output logic [1:0]                      o_b_bresp,
  output logic                            o_b_bvalid,
  input  logic                            i_b_bready,
  input  logic [axi_pkg::AXI_ADDR_W-1:0]  i_b_araddr,
  input  logic [7:0]                      i_b_arlen,
  input  logic [2:0]                      i_b_arsize,
  input  logic [1:0]                      i_b_arburst,
  input  logic [1:0]                      i_b_arlock,
  input  logic [3:0]                      i_b_arcache,
  input  logic [2:0]                      i_b_arprot,
  input  logic                            i_b_arvalid,
  output logic                            o_b_arready,
  output logic [axi_pkg::AXI_DATA_W-1:0]  o_b_rdata,
  output logic [1:0]                      o_b_rresp,
  output logic                            o_b_rlast,
  output logic                            o_b_rvalid,
  input  logic                            i_b_rready
);

  logic aw_gnt;
  logic ar_gnt;
  logic w_own;
  logic wr_busy;

  axi_if if_a ();
  axi_if if_b ();
  axi_if if_s ();  // Shared bus to the SRAM

  // --------------------------------------------------
  // Master a port wiring
  assign if_a.awaddr  = i_a_awaddr;
  assign if_a.awlen   = i_a_awlen;
  assign if_a.awsize  = i_a_awsize;
  assign if_a.awburst = i_a_awburst;
  assign if_a.awlock  = i_a_awlock;
  assign if_a.awcache = i_a_awcache;
  assign if_a.awprot  = i_a_awprot;
  assign if_a.awvalid = i_a_awvalid;
  assign o_a_awready  = if_a.awready;
  assign if_a.wdata   = i_a_wdata;
  assign if_a.wstrb   = i_a_wstrb;
  assign if_a.wlast   = i_a_wlast;
  assign if_a.wvalid  = i_a_wvalid;
  assign o_a_wready   = if_a.wready;
  assign o_a_bresp    = if_a.bresp;
  assign o_a_bvalid   = if_a.bvalid;
  assign if_a.bready  = i_a_bready;
  assign if_a.araddr  = i_a_araddr;
  assign if_a.arlen   = i_a_arlen;
  assign if_a.arsize  = i_a_arsize;
  assign if_a.arburst = i_a_arburst;
  assign if_a.arlock  = i_a_arlock;
  assign if_a.arcache = i_a_arcache;
  assign if_a.arprot  = i_a_arprot;
  assign if_a.arvalid = i_a_arvalid;
  assign o_a_arready  = if_a.arready;
  assign o_a_rdata    = if_a.rdata;
  assign o_a_rresp    = if_a.rresp;
  assign o_a_rlast    = if_a.rlast;
  assign o_a_rvalid   = if_a.rvalid;
  assign if_a.rready  = i_a_rready;

  // Master b port wiring
  assign if_b.awaddr  = i_b_awaddr;
  assign if_b.awlen   = i_b_awlen;
  assign if_b.awsize  = i_b_awsize;
  assign if_b.awburst = i_b_awburst;
  assign if_b.awlock  = i_b_awlock;
  assign if_b.awcache = i_b_awcache;
  assign if_b.awprot  = i_b_awprot;
  assign if_b.awvalid = i_b_awvalid;
  assign o_b_awready  = if_b.awready;
  assign if_b.wdata   = i_b_wdata;
  assign if_b.wstrb   = i_b_wstrb;
  assign if_b.wlast   = i_b_wlast;
  assign if_b.wvalid  = i_b_wvalid;
  assign o_b_wready   = if_b.wready;
  assign o_b_bresp    = if_b.bresp;
  assign o_b_bvalid   = if_b.bvalid;
  assign if_b.bready  = i_b_bready;
  assign if_b.araddr  = i_b_araddr;
  assign if_b.arlen   = i_b_arlen;
  assign if_b.arsize  = i_b_arsize;
  assign if_b.arburst = i_b_arburst;
  assign if_b.arlock  = i_b_arlock;
  assign if_b.arcache = i_b_arcache;
  assign if_b.arprot  = i_b_arprot;
  assign if_b.arvalid = i_b_arvalid;
  assign o_b_arready  = if_b.arready;
  assign o_b_rdata    = if_b.rdata;
  assign o_b_rresp    = if_b.rresp;
  assign o_b_rlast    = if_b.rlast;
  assign o_b_rvalid   = if_b.rvalid;
  assign if_b.rready  = i_b_rready;

  // --------------------------------------------------
  axi_arb_ctrl u_arb_ctrl (
    .i_aclk      (i_aclk),
    .i_arst_n    (i_arst_n),
    .i_a_awvalid (i_a_awvalid),
    .i_b_awvalid (i_b_awvalid),
    .i_a_arvalid (i_a_arvalid),
    .i_b_arvalid (i_b_arvalid),
    .i_s_awready (if_s.awready),
    .i_s_arready (if_s.arready),
    .i_s_bvalid  (if_s.bvalid),
    .i_s_bready  (if_s.bready),
    .o_aw_gnt    (aw_gnt),
    .o_ar_gnt    (ar_gnt),
    .o_w_own     (w_own),
    .o_wr_busy   (wr_busy)
  );

  axi_req_mux u_req_mux (
    .i_aw_gnt  (aw_gnt),
    .i_ar_gnt  (ar_gnt),
    .i_w_own   (w_own),
    .i_wr_busy (wr_busy),
    .m_a       (if_a),
    .m_b       (if_b),
    .s         (if_s)
  );

  axi_rsp_demux u_rsp_demux (
    .s   (if_s),
    .m_a (if_a),
    .m_b (if_b)
  );

  axi_sram_slave u_sram (
    .i_aclk   (i_aclk),
    .i_arst_n (i_arst_n),
    .s        (if_s)
  );

endmodule

// File: src/axi_sram_slave.sv
// Burst AXI SRAM slave
`timescale 1ns/1ns

module axi_sram_slave (
  input  logic i_aclk,
  input  logic i_arst_n,
  axi_if.slv   s
);
  import axi_pkg::*;

  logic [AXI_DATA_W-1:0] mem [MEM_WORDS];
  logic [1:0]            state;
  logic [LEN_W-1:0]      cnt_q;
  logic [LEN_W-1:0]      len_q;
  logic [IDX_W-1:0]      idx_q;
  logic [IDX_W-1:0]      idx_nxt;
  logic [AXI_ID_W-1:0]   id_q;
  logic [AXI_DATA_W-1:0] rdata_q;
  logic                  aw_hs;
  logic                  ar_hs;
  logic                  w_hs;
  logic                  r_hs;

  // Longer bursts stop at MAX_BURST beats
  function automatic logic [LEN_W-1:0] clip_len(input logic [7:0] len);
    if (len >= MAX_BURST) begin
      return LEN_W'(MAX_BURST - 1);
    end
    return len[LEN_W-1:0];
  endfunction

  // --------------------------------------------------
  // Channel outputs
  assign s.awready = (state == ST_IDLE);
  assign s.arready = (state == ST_IDLE) & ~s.awvalid;  // Write wins a tie
  assign s.wready  = (state == ST_WDATA);
  assign s.bvalid  = (state == ST_WRESP);
  assign s.bid     = id_q;
  assign s.bresp   = RESP_OKAY;
  assign s.rvalid  = (state == ST_RDATA);
  assign s.rid     = id_q;
  assign s.rdata   = rdata_q;
  assign s.rresp   = RESP_OKAY;
  assign s.rlast   = (cnt_q == len_q);

  assign aw_hs   = s.awvalid & s.awready;
  assign ar_hs   = s.arvalid & s.arready;
  assign w_hs    = s.wvalid & s.wready;
  assign r_hs    = s.rvalid & s.rready;
  assign idx_nxt = idx_q + 1'b1;

  // --------------------------------------------------
  // Controller
  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= ST_IDLE;
      cnt_q <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          cnt_q <= '0;
          if (aw_hs) begin
            state <= ST_WDATA;
          end else if (ar_hs) begin
            state <= ST_RDATA;
          end
        end
        ST_WDATA: begin
          if (w_hs && s.wlast) begin
            state <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          if (s.bready) begin
            state <= ST_IDLE;
          end
        end
        ST_RDATA: begin
          if (r_hs && s.rlast) begin
            state <= ST_IDLE;
          end else if (r_hs) begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Transaction fields, array and read word
  always_ff @(posedge i_aclk) begin
    if (aw_hs) begin
      id_q  <= s.awid;
      idx_q <= s.awaddr[IDX_LSB +: IDX_W];
      len_q <= clip_len(s.awlen);
    end else if (ar_hs) begin
      id_q    <= s.arid;
      idx_q   <= s.araddr[IDX_LSB +: IDX_W];
      len_q   <= clip_len(s.arlen);
      rdata_q <= mem[s.araddr[IDX_LSB +: IDX_W]];
    end else if (w_hs) begin
      idx_q <= idx_nxt;
    end else if (r_hs && !s.rlast) begin
      idx_q   <= idx_nxt;
      rdata_q <= mem[idx_nxt];  // Next beat ready one cycle on
    end

    if (w_hs) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (s.wstrb[i]) begin
          mem[idx_q][8*i +: 8] <= s.wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: src/axi_rsp_demux.sv
// AXI response demux by ID
`timescale 1ns/1ns

module axi_rsp_demux (
  axi_if.mst s,
  axi_if.slv m_a,
  axi_if.slv m_b
);
  import axi_pkg::*;

  logic b_sel;
  logic r_sel;

  assign b_sel = (s.bid[0] == ID_LSU[0]);  // 1 routes to b
  assign r_sel = (s.rid[0] == ID_LSU[0]);

  // Write response
  assign m_a.bvalid = s.bvalid & ~b_sel;
  assign m_b.bvalid = s.bvalid &  b_sel;
  assign m_a.bid    = s.bid;
  assign m_b.bid    = s.bid;
  assign m_a.bresp  = s.bresp;
  assign m_b.bresp  = s.bresp;
  assign s.bready   = b_sel ? m_b.bready : m_a.bready;

  // Read data
  assign m_a.rvalid = s.rvalid & ~r_sel;
  assign m_b.rvalid = s.rvalid &  r_sel;
  assign m_a.rid    = s.rid;
  assign m_b.rid    = s.rid;
  assign m_a.rdata  = s.rdata;
  assign m_b.rdata  = s.rdata;
  assign m_a.rresp  = s.rresp;
  assign m_b.rresp  = s.rresp;
  assign m_a.rlast  = s.rlast;
  assign m_b.rlast  = s.rlast;
  assign s.rready   = r_sel ? m_b.rready : m_a.rready;

endmodule

// File: src/axi_req_mux.sv
// AXI request channel mux
`timescale 1ns/1ns

module axi_req_mux (
  input  logic i_aw_gnt,
  input  logic i_ar_gnt,
  input  logic i_w_own,
  input  logic i_wr_busy,
  axi_if.slv   m_a,
  axi_if.slv   m_b,
  axi_if.mst   s
);
  import axi_pkg::*;

  logic aw_req;

  // --------------------------------------------------
  // Write address, blocked while a write is open
  assign aw_req      = i_aw_gnt ? m_b.awvalid : m_a.awvalid;
  assign s.awvalid   = aw_req & ~i_wr_busy;
  assign s.awid      = i_aw_gnt ? ID_LSU : ID_IFU;
  assign s.awaddr    = i_aw_gnt ? m_b.awaddr  : m_a.awaddr;
  assign s.awlen     = i_aw_gnt ? m_b.awlen   : m_a.awlen;
  assign s.awsize    = i_aw_gnt ? m_b.awsize  : m_a.awsize;
  assign s.awburst   = i_aw_gnt ? m_b.awburst : m_a.awburst;
  assign s.awlock    = i_aw_gnt ? m_b.awlock  : m_a.awlock;
  assign s.awcache   = i_aw_gnt ? m_b.awcache : m_a.awcache;
  assign s.awprot    = i_aw_gnt ? m_b.awprot  : m_a.awprot;
  assign m_a.awready = s.awready & s.awvalid & ~i_aw_gnt;
  assign m_b.awready = s.awready & s.awvalid &  i_aw_gnt;

  // Write data goes to the recorded owner
  assign s.wvalid    = (i_w_own ? m_b.wvalid : m_a.wvalid) & i_wr_busy;
  assign s.wid       = i_w_own ? ID_LSU : ID_IFU;
  assign s.wdata     = i_w_own ? m_b.wdata : m_a.wdata;
  assign s.wstrb     = i_w_own ? m_b.wstrb : m_a.wstrb;
  assign s.wlast     = i_w_own ? m_b.wlast : m_a.wlast;
  assign m_a.wready  = s.wready & i_wr_busy & ~i_w_own;
  assign m_b.wready  = s.wready & i_wr_busy &  i_w_own;

  // --------------------------------------------------
  // Read address
  assign s.arvalid   = i_ar_gnt ? m_b.arvalid : m_a.arvalid;
  assign s.arid      = i_ar_gnt ? ID_LSU : ID_IFU;
  assign s.araddr    = i_ar_gnt ? m_b.araddr  : m_a.araddr;
  assign s.arlen     = i_ar_gnt ? m_b.arlen   : m_a.arlen;
  assign s.arsize    = i_ar_gnt ? m_b.arsize  : m_a.arsize;
  assign s.arburst   = i_ar_gnt ? m_b.arburst : m_a.arburst;
  assign s.arlock    = i_ar_gnt ? m_b.arlock  : m_a.arlock;
  assign s.arcache   = i_ar_gnt ? m_b.arcache : m_a.arcache;
  assign s.arprot    = i_ar_gnt ? m_b.arprot  : m_a.arprot;
  assign m_a.arready = s.arready & s.arvalid & ~i_ar_gnt;
  assign m_b.arready = s.arready & s.arvalid &  i_ar_gnt;

endmodule

// File: src/axi_arb_ctrl.sv
// AXI two-master grant control
`timescale 1ns/1ns

module axi_arb_ctrl (
  input  logic i_aclk,
  input  logic i_arst_n,
  input  logic i_a_awvalid,
  input  logic i_b_awvalid,
  input  logic i_a_arvalid,
  input  logic i_b_arvalid,
  input  logic i_s_awready,
  input  logic i_s_arready,
  input  logic i_s_bvalid,
  input  logic i_s_bready,
  output logic o_aw_gnt,  // 0 for a, 1 for b
  output logic o_ar_gnt,
  output logic o_w_own,
  output logic o_wr_busy
);

  logic aw_lock;
  logic aw_gnt_q;
  logic aw_req;
  logic aw_hs;
  logic ar_lock;
  logic ar_gnt_q;
  logic ar_req;
  logic ar_hs;

  // --------------------------------------------------
  // Priority to a while unlocked
  assign o_aw_gnt = aw_lock ? aw_gnt_q : (~i_a_awvalid & i_b_awvalid);
  assign aw_req   = o_aw_gnt ? i_b_awvalid : i_a_awvalid;
  assign aw_hs    = aw_req & ~o_wr_busy & i_s_awready;

  assign o_ar_gnt = ar_lock ? ar_gnt_q : (~i_a_arvalid & i_b_arvalid);
  assign ar_req   = o_ar_gnt ? i_b_arvalid : i_a_arvalid;
  assign ar_hs    = ar_req & i_s_arready;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      aw_lock   <= 1'b0;
      aw_gnt_q  <= 1'b0;
      ar_lock   <= 1'b0;
      ar_gnt_q  <= 1'b0;
      o_w_own   <= 1'b0;
      o_wr_busy <= 1'b0;
    end else begin
      aw_lock  <= aw_req & ~aw_hs;  // Pending request keeps its grant
      aw_gnt_q <= o_aw_gnt;
      ar_lock  <= ar_req & ~ar_hs;
      ar_gnt_q <= o_ar_gnt;

      // W beats follow the AW winner until B
      if (aw_hs) begin
        o_w_own   <= o_aw_gnt;
        o_wr_busy <= 1'b1;
      end else if (i_s_bvalid && i_s_bready) begin
        o_wr_busy <= 1'b0;
      end
    end
  end

endmodule

// File: src/axi_if.sv
// AXI channel bundle
`timescale 1ns/1ns

interface axi_if;
  import axi_pkg::*;

  // --------------------------------------------------
  // Write address / data / response
  logic [AXI_ID_W-1:0]   awid;
  logic [AXI_ADDR_W-1:0] awaddr;
  logic [7:0]            awlen;
  logic [2:0]            awsize;
  logic [1:0]            awburst;
  logic [1:0]            awlock;
  logic [3:0]            awcache;
  logic [2:0]            awprot;
  logic                  awvalid;
  logic                  awready;

  logic [AXI_ID_W-1:0]   wid;
  logic [AXI_DATA_W-1:0] wdata;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  wlast;
  logic                  wvalid;
  logic                  wready;

  logic [AXI_ID_W-1:0]   bid;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;

  // --------------------------------------------------
  // Read address / data
  logic [AXI_ID_W-1:0]   arid;
  logic [AXI_ADDR_W-1:0] araddr;
  logic [7:0]            arlen;
  logic [2:0]            arsize;
  logic [1:0]            arburst;
  logic [1:0]            arlock;
  logic [3:0]            arcache;
  logic [2:0]            arprot;
  logic                  arvalid;
  logic                  arready;

  logic [AXI_ID_W-1:0]   rid;
  logic [AXI_DATA_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  rready;

  modport mst (
    output awid, awaddr, awlen, awsize, awburst, awlock, awcache, awprot, awvalid,
    input  awready,
    output wid, wdata, wstrb, wlast, wvalid,
    input  wready,
    input  bid, bresp, bvalid,
    output bready,
    output arid, araddr, arlen, arsize, arburst, arlock, arcache, arprot, arvalid,
    input  arready,
    input  rid, rdata, rresp, rlast, rvalid,
    output rready
  );

  modport slv (
    input  awid, awaddr, awlen, awsize, awburst, awlock, awcache, awprot, awvalid,
    output awready,
    input  wid, wdata, wstrb, wlast, wvalid,
    output wready,
    output bid, bresp, bvalid,
    input  bready,
    input  arid, araddr, arlen, arsize, arburst, arlock, arcache, arprot, arvalid,
    output arready,
    output rid, rdata, rresp, rlast, rvalid,
    input  rready
  );

endinterface

// File: src/axi_pkg.sv
// AXI memory system definitions
package axi_pkg;

  // Bus widths
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;
  localparam int AXI_ID_W   = 4;

  // Master tags, bit 0 routes the response
  localparam logic [AXI_ID_W-1:0] ID_IFU = 4'd0;
  localparam logic [AXI_ID_W-1:0] ID_LSU = 4'd1;

  // SRAM geometry
  localparam int MEM_WORDS = 1024;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int IDX_LSB   = $clog2(AXI_STRB_W);  // Word index from addr[12:3]
  localparam int MAX_BURST = 16;
  localparam int LEN_W     = $clog2(MAX_BURST);

  localparam logic [1:0] RESP_OKAY = 2'b00;

  // SRAM controller states
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WDATA = 2'd1;
  localparam logic [1:0] ST_WRESP = 2'd2;
  localparam logic [1:0] ST_RDATA = 2'd3;

endpackage
